/* Makefile */
VERILATOR ?= verilator
TOP ?= tbCpu
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FILELIST ?= filelist.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* aluUnit.sv */
`default_nettype none

module aluUnit (
	input logic [cpuPkg::WordSize-1:0] a,
	input logic [cpuPkg::WordSize-1:0] b,
	input cpuPkg::aluOpT op,
	input logic [1:0] branchKind,
	output logic [cpuPkg::WordSize-1:0] result,
	output logic branchTaken
);
	localparam int W = cpuPkg::WordSize;

	always_comb begin
		case (op)
			cpuPkg::AluAdd: result = a + b;
			cpuPkg::AluSub: result = a - b;
			cpuPkg::AluAnd: result = a & b;
			cpuPkg::AluOr: result = a | b;
			cpuPkg::AluNot: result = ~a;
			cpuPkg::AluTcp: result = ~a + W'(1);
			cpuPkg::AluShl: result = {a[W-2:0], 1'b0};
			cpuPkg::AluShr: result = {a[W-1], a[W-1:1]}; // arithmetic shift that keeps the sign bit.
			cpuPkg::AluPassB: result = b;
			default: result = '0;
		endcase
	end

	// branchKind is the low two opcode bits of a branch.
	always_comb begin
		case (branchKind)
			2'd0: branchTaken = (a != b);
			2'd1: branchTaken = (a == b);
			2'd2: branchTaken = !a[W-1] && (a != '0);
			default: branchTaken = a[W-1];
		endcase
	end
endmodule

`default_nettype wire

/* busPkg.sv */
`default_nettype none

package busPkg;
	localparam int AddrWidth = 16;
	localparam int DataWidth = 16;

	// master to slave half of a Wishbone classic port.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [AddrWidth-1:0] adr;
		logic [DataWidth-1:0] datW;
	} wbReqT;

	typedef struct packed {
		logic ack;
		logic [DataWidth-1:0] datR; // valid in the ack cycle.
	} wbRspT;
endpackage

`default_nettype wire

/* controlUnit.sv */
`default_nettype none

module controlUnit (
	input logic [cpuPkg::WordSize-1:0] instr,
	output cpuPkg::controlT ctrl
);
	cpuPkg::opcodeT opcode;
	cpuPkg::funcT func;

	assign opcode = cpuPkg::opcodeT'(instr[cpuPkg::OpLsb +: cpuPkg::OpWidth]);
	assign func = cpuPkg::funcT'(instr[cpuPkg::FuncWidth-1:0]);

	// register to register operation writing rd.
	function automatic cpuPkg::controlT rType(input cpuPkg::aluOpT op);
		cpuPkg::controlT c;
		c = '0;
		c.regDst = 1'b1;
		c.regWrite = 1'b1;
		c.aluOp = op;
		return c;
	endfunction

	always_comb begin
		ctrl = '0;
		case (opcode)
			cpuPkg::OpRType: begin
				case (func)
					cpuPkg::FnAdd: ctrl = rType(cpuPkg::AluAdd);
					cpuPkg::FnSub: ctrl = rType(cpuPkg::AluSub);
					cpuPkg::FnAnd: ctrl = rType(cpuPkg::AluAnd);
					cpuPkg::FnOrr: ctrl = rType(cpuPkg::AluOr);
					cpuPkg::FnNot: ctrl = rType(cpuPkg::AluNot);
					cpuPkg::FnTcp: ctrl = rType(cpuPkg::AluTcp);
					cpuPkg::FnShl: ctrl = rType(cpuPkg::AluShl);
					cpuPkg::FnShr: ctrl = rType(cpuPkg::AluShr);
					cpuPkg::FnJpr: ctrl.jump = 1'b1;
					cpuPkg::FnJrl: begin
						ctrl.jump = 1'b1;
						ctrl.linkWrite = 1'b1;
					end
					cpuPkg::FnWwd: ctrl.outputWrite = 1'b1;
					cpuPkg::FnHlt: ctrl.halt = 1'b1;
					default: ctrl = '0;
				endcase
			end
			cpuPkg::OpBne, cpuPkg::OpBeq, cpuPkg::OpBgz, cpuPkg::OpBlz: begin
				ctrl.branch = 1'b1; // the ALU compares rs with rt.
				ctrl.aluOp = cpuPkg::AluSub;
			end
			cpuPkg::OpAdi, cpuPkg::OpOri, cpuPkg::OpLhi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				if (opcode == cpuPkg::OpAdi) begin
					ctrl.aluOp = cpuPkg::AluAdd;
					ctrl.extendKind = cpuPkg::ExtSign;
				end else if (opcode == cpuPkg::OpOri) begin
					ctrl.aluOp = cpuPkg::AluOr;
					ctrl.extendKind = cpuPkg::ExtZero;
				end else begin
					ctrl.aluOp = cpuPkg::AluPassB;
					ctrl.extendKind = cpuPkg::ExtHigh;
				end
			end
			cpuPkg::OpLwd, cpuPkg::OpSwd: begin
				ctrl.aluSrc = 1'b1; // address is rs plus the signed offset.
				ctrl.aluOp = cpuPkg::AluAdd;
				ctrl.extendKind = cpuPkg::ExtSign;
				ctrl.memWrite = (opcode == cpuPkg::OpSwd);
				ctrl.memRead = (opcode == cpuPkg::OpLwd);
				ctrl.memToReg = (opcode == cpuPkg::OpLwd);
				ctrl.regWrite = (opcode == cpuPkg::OpLwd);
			end
			cpuPkg::OpJmp: ctrl.jump = 1'b1;
			cpuPkg::OpJal: begin
				ctrl.jump = 1'b1;
				ctrl.linkWrite = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end
endmodule

`default_nettype wire

/* cpu.sv */
`default_nettype none

module cpu (
	input logic clk,
	input logic rstN,
	output busPkg::wbReqT busReq,
	input busPkg::wbRspT busRsp,
	output logic [cpuPkg::WordSize-1:0] outWord,
	output logic outValid,
	output logic halted
);
	logic [cpuPkg::WordSize-1:0] instr;
	cpuPkg::controlT ctrl;
	logic [cpuPkg::WordSize-1:0] aluA;
	logic [cpuPkg::WordSize-1:0] aluB;
	logic [cpuPkg::WordSize-1:0] aluResult;
	cpuPkg::aluOpT aluOp;
	logic [1:0] branchKind;
	logic branchTaken;
	logic [cpuPkg::RegAddrWidth-1:0] regAddrA;
	logic [cpuPkg::RegAddrWidth-1:0] regAddrB;
	logic [cpuPkg::RegAddrWidth-1:0] regWriteAddr;
	logic [cpuPkg::WordSize-1:0] regWriteData;
	logic [cpuPkg::WordSize-1:0] regDataA;
	logic [cpuPkg::WordSize-1:0] regDataB;
	logic regWrite;

	controlUnit control0 (.instr(instr), .ctrl(ctrl));

	datapath datapath0 (
		.clk(clk), .rstN(rstN), .busReq(busReq), .busRsp(busRsp),
		.instr(instr), .ctrl(ctrl), .aluA(aluA), .aluB(aluB), .aluOp(aluOp),
		.branchKind(branchKind), .aluResult(aluResult), .branchTaken(branchTaken),
		.regAddrA(regAddrA), .regAddrB(regAddrB), .regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData), .regWrite(regWrite), .regDataA(regDataA),
		.regDataB(regDataB), .outWord(outWord), .outValid(outValid), .halted(halted)
	);

	aluUnit alu0 (
		.a(aluA), .b(aluB), .op(aluOp), .branchKind(branchKind),
		.result(aluResult), .branchTaken(branchTaken)
	);

	registerFile regs0 (
		.clk(clk), .rstN(rstN), .readAddrA(regAddrA), .readAddrB(regAddrB),
		.writeAddr(regWriteAddr), .writeData(regWriteData), .writeEnable(regWrite),
		.readDataA(regDataA), .readDataB(regDataB)
	);
endmodule

`default_nettype wire

/* cpuMonitor.sv */
`default_nettype none

module cpuMonitor (
	input logic clk,
	input logic rstN,
	input busPkg::wbReqT busReq,
	input busPkg::wbRspT busRsp,
	input logic [cpuPkg::WordSize-1:0] outWord,
	input logic outValid,
	input logic halted,
	output logic done,
	output int testsRun,
	output int testsFailed
);
	localparam int Timeout = 5000;
	localparam int QuietCycles = 20;

	logic [15:0] stim [0:511];
	logic [15:0] gotOut [$];
	logic [15:0] gotAdr [$];
	logic [15:0] gotDat [$];
	int nOut;
	int nStore;

	always @(posedge clk) begin
		if (rstN) begin
			if (outValid) gotOut.push_back(outWord);
			if (busReq.cyc && busReq.stb && busReq.we && busRsp.ack) begin
				gotAdr.push_back(busReq.adr);
				gotDat.push_back(busReq.datW);
			end
		end
	end

	task automatic finishTest(input string name, input int errors);
		testsRun++;
		if (errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d error(s)", name, errors);
		end
	endtask

	task automatic compareOutputWords();
		int errors;
		int cycles;
		errors = 0;
		for (cycles = 0; cycles < Timeout && gotOut.size() < nOut && !halted; cycles++) begin
			@(posedge clk);
		end
		if (gotOut.size() < nOut) begin
			$display("only %0d of %0d output words arrived", gotOut.size(), nOut);
			errors++;
		end else begin
			for (int i = 0; i < nOut; i++) begin
				if (gotOut[i] !== stim[257 + i]) begin
					$display("ERR outWord[%0d] got %h expected %h", i, gotOut[i], stim[257 + i]);
					errors++;
				end
			end
		end
		finishTest("output words", errors);
	endtask

	task automatic compareStores();
		int errors;
		int cycles;
		errors = 0;
		for (cycles = 0; cycles < Timeout && gotAdr.size() < nStore && !halted; cycles++) begin
			@(posedge clk);
		end
		if (gotAdr.size() < nStore) begin
			$display("only %0d of %0d stores arrived", gotAdr.size(), nStore);
			errors++;
		end else begin
			for (int i = 0; i < nStore; i++) begin
				if (gotAdr[i] !== stim[385 + 2 * i]) begin
					$display("ERR busReq.adr store %0d got %h expected %h", i, gotAdr[i],
						stim[385 + 2 * i]);
					errors++;
				end
				if (gotDat[i] !== stim[386 + 2 * i]) begin
					$display("ERR busReq.datW store %0d got %h expected %h", i, gotDat[i],
						stim[386 + 2 * i]);
					errors++;
				end
			end
		end
		finishTest("stores", errors);
	endtask

	task automatic awaitHalt();
		int errors;
		int cycles;
		errors = 0;
		for (cycles = 0; cycles < Timeout && !halted; cycles++) begin
			@(posedge clk);
		end
		if (!halted) begin
			$display("the processor did not halt in time");
			errors++;
		end
		finishTest("halt", errors);
	endtask

	// after the halt nothing may move on the bus or the output port.
	task automatic watchQuietBus();
		int errors;
		errors = 0;
		for (int i = 0; i < QuietCycles; i++) begin
			@(posedge clk);
			if (busReq.cyc || busReq.stb) begin
				$display("a bus cycle started after the halt");
				errors++;
			end
			if (!halted) begin
				$display("halted dropped after the halt");
				errors++;
			end
		end
		if (gotOut.size() != nOut || gotAdr.size() != nStore) begin
			$display("extra output words or stores were seen");
			errors++;
		end
		finishTest("quiet after halt", errors);
	endtask

	initial begin
		int cycles;
		done = 1'b0;
		testsRun = 0;
		testsFailed = 0;
		$readmemh("cpu_stim.txt", stim);
		nOut = int'(stim[256]);
		nStore = int'(stim[384]);
		for (cycles = 0; cycles < Timeout && !rstN; cycles++) begin
			@(posedge clk);
		end
		if (!rstN) begin
			$display("reset was never released");
			testsRun++;
			testsFailed++;
		end else begin
			compareOutputWords();
			compareStores();
			awaitHalt();
			watchQuietBus();
		end
		done = 1'b1;
	end
endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;
	localparam int WordSize = 16;
	localparam int NumRegs = 4;
	localparam int RegAddrWidth = $clog2(NumRegs);

	// instruction field layout.
	localparam int OpWidth = 4;
	localparam int FuncWidth = 6;
	localparam int ImmWidth = 8;
	localparam int TargetWidth = 12;
	localparam int OpLsb = 12;
	localparam int RsLsb = 10;
	localparam int RtLsb = 8;
	localparam int RdLsb = 6;

	localparam logic [RegAddrWidth-1:0] LinkReg = 2'd2; // jal and jrl write the return value here.

	typedef enum logic [OpWidth-1:0] {
		OpBne = 4'd0,
		OpBeq = 4'd1,
		OpBgz = 4'd2,
		OpBlz = 4'd3,
		OpAdi = 4'd4,
		OpOri = 4'd5,
		OpLhi = 4'd6,
		OpLwd = 4'd7,
		OpSwd = 4'd8,
		OpJmp = 4'd9,
		OpJal = 4'd10,
		OpRType = 4'd15
	} opcodeT;

	typedef enum logic [FuncWidth-1:0] {
		FnAdd = 6'd0,
		FnSub = 6'd1,
		FnAnd = 6'd2,
		FnOrr = 6'd3,
		FnNot = 6'd4,
		FnTcp = 6'd5,
		FnShl = 6'd6,
		FnShr = 6'd7,
		FnJpr = 6'd25,
		FnJrl = 6'd26,
		FnWwd = 6'd28,
		FnHlt = 6'd29
	} funcT;

	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluNot,
		AluTcp,
		AluShl,
		AluShr,
		AluPassB,
		AluZero
	} aluOpT;

	typedef enum logic [1:0] {
		ExtSign,
		ExtZero,
		ExtHigh
	} extendT;

	typedef struct packed {
		logic jump;
		logic branch;
		logic memToReg;
		logic memRead;
		logic memWrite;
		logic regDst;
		logic regWrite;
		logic linkWrite;
		logic outputWrite;
		logic halt;
		aluOpT aluOp;
		logic aluSrc;
		extendT extendKind;
	} controlT;
endpackage

`default_nettype wire

/* cpu_checker.sv */
`default_nettype none

module cpuChecker (
	input logic clk,
	input logic rstN,
	input busPkg::wbReqT busReq,
	input busPkg::wbRspT busRsp,
	input logic outValid,
	input logic halted
);
	stbInsideCyc: assert property (@(posedge clk) disable iff (!rstN)
		busReq.stb |-> busReq.cyc)
		else $error("stb is high while cyc is low");

	// a waiting request keeps its address, direction and data.
	requestHeld: assert property (@(posedge clk) disable iff (!rstN)
		(busReq.stb && !busRsp.ack) |=> (busReq.stb && $stable(busReq.adr)
			&& $stable(busReq.we) && $stable(busReq.datW)))
		else $error("bus request changed before ack");

	noOutputAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
		halted |-> !outValid)
		else $error("outValid while halted");

	haltSticky: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> halted)
		else $error("halted fell");
endmodule

bind cpu cpuChecker checker0 (
	.clk(clk), .rstN(rstN), .busReq(busReq), .busRsp(busRsp),
	.outValid(outValid), .halted(halted)
);

`default_nettype wire

/* cpu_stim.txt */
// section @000 holds the program image, one instruction word per address.
// section @100 holds the output word count, then the words; @180 the store count, then adr/data pairs.
@000
6112 5534 F41C 42FD F6C0 FC1C F6C1 FC1C
F6C2 FC1C F6C3 FC1C F4C4 FC1C F8C5 FC1C
F4C6 FC1C F8C7 FC1C
// stores to 00C1 and 00C0, loads back, then r0 cleared.
53C0 8D01 8E00 7C01 F01C 7F00 FC1C F001
// eight branch blocks: mark, branch, fall-through mark, write-word.
4001 0601 4010 F01C
4001 0B01 4010 F01C
4001 1B01 4010 F01C
4001 1601 4010 F01C
4001 2401 4010 F01C
4001 2801 4010 F01C
4001 3801 4010 F01C
4001 3401 4010 F01C
// jmp, jal, jpr, jrl and the final halt at 004B.
903F F41C F01D A042 F41C F01D F81C 43FE
FC19 F01D 4F04 FC1A F41C F01D F81C F01D
@100
0015
1234 1231 1237 1234 FFFD EDCB 0003 2468
FFFE 1234 FFFD
0001 0012 0013 0024 0025 0036 0037 0048
0040 0048
@180
0002
00C1 1234
00C0 FFFD

/* datapath.sv */
`default_nettype none

module datapath (
	input logic clk,
	input logic rstN,
	output busPkg::wbReqT busReq,
	input busPkg::wbRspT busRsp,
	output logic [cpuPkg::WordSize-1:0] instr,
	input cpuPkg::controlT ctrl,
	output logic [cpuPkg::WordSize-1:0] aluA,
	output logic [cpuPkg::WordSize-1:0] aluB,
	output cpuPkg::aluOpT aluOp,
	output logic [1:0] branchKind,
	input logic [cpuPkg::WordSize-1:0] aluResult,
	input logic branchTaken,
	output logic [cpuPkg::RegAddrWidth-1:0] regAddrA,
	output logic [cpuPkg::RegAddrWidth-1:0] regAddrB,
	output logic [cpuPkg::RegAddrWidth-1:0] regWriteAddr,
	output logic [cpuPkg::WordSize-1:0] regWriteData,
	output logic regWrite,
	input logic [cpuPkg::WordSize-1:0] regDataA,
	input logic [cpuPkg::WordSize-1:0] regDataB,
	output logic [cpuPkg::WordSize-1:0] outWord,
	output logic outValid,
	output logic halted
);
	localparam int W = cpuPkg::WordSize;
	localparam int Imm = cpuPkg::ImmWidth;

	typedef enum logic [2:0] {
		StFetch,
		StDecode,
		StExecute,
		StMemory,
		StWriteBack,
		StHalted
	} stateT;

	stateT state;
	busPkg::wbReqT reqQ;
	logic [W-1:0] pc;
	logic [W-1:0] irQ;
	logic [W-1:0] mdrQ;
	logic [W-1:0] aQ;
	logic [W-1:0] bQ;
	logic [W-1:0] aluOutQ;
	logic [W-1:0] nextPcQ;
	logic [W-1:0] pcPlusOne;
	logic [W-1:0] immExt;
	logic [W-1:0] nextPc;
	logic jumpReg;

	assign instr = irQ;
	assign busReq = reqQ;
	assign regAddrA = irQ[cpuPkg::RsLsb +: cpuPkg::RegAddrWidth];
	assign regAddrB = irQ[cpuPkg::RtLsb +: cpuPkg::RegAddrWidth];
	assign pcPlusOne = pc + W'(1);
	assign jumpReg = cpuPkg::opcodeT'(irQ[cpuPkg::OpLsb +: cpuPkg::OpWidth]) == cpuPkg::OpRType;

	always_comb begin
		case (ctrl.extendKind)
			cpuPkg::ExtZero: immExt = {{(W-Imm){1'b0}}, irQ[Imm-1:0]};
			cpuPkg::ExtHigh: immExt = {irQ[Imm-1:0], {(W-Imm){1'b0}}};
			default: immExt = {{(W-Imm){irQ[Imm-1]}}, irQ[Imm-1:0]};
		endcase
	end

	assign aluA = aQ;
	assign aluB = ctrl.aluSrc ? immExt : bQ;
	assign aluOp = ctrl.aluOp;
	assign branchKind = irQ[cpuPkg::OpLsb +: 2];

	always_comb begin
		nextPc = pcPlusOne;
		if (ctrl.jump) begin
			nextPc = jumpReg ? aQ : {pc[W-1:cpuPkg::TargetWidth], irQ[cpuPkg::TargetWidth-1:0]};
		end else if (ctrl.branch && branchTaken) begin
			nextPc = pcPlusOne + immExt; // branches decode with sign extension.
		end
	end

	always_comb begin
		if (ctrl.linkWrite) begin
			regWriteAddr = cpuPkg::LinkReg;
		end else if (ctrl.regDst) begin
			regWriteAddr = irQ[cpuPkg::RdLsb +: cpuPkg::RegAddrWidth];
		end else begin
			regWriteAddr = irQ[cpuPkg::RtLsb +: cpuPkg::RegAddrWidth];
		end
	end

	assign regWriteData = ctrl.linkWrite ? pcPlusOne : (ctrl.memToReg ? mdrQ : aluOutQ);
	assign regWrite = (state == StWriteBack) && (ctrl.regWrite || ctrl.linkWrite);
	assign outWord = aQ;
	assign outValid = (state == StWriteBack) && ctrl.outputWrite;
	assign halted = (state == StHalted);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= StFetch;
			pc <= '0;
			reqQ <= '0;
		end else begin
			case (state)
				StFetch: begin
					if (!reqQ.cyc) begin // first fetch after reset.
						reqQ <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: pc, datW: '0};
					end else if (busRsp.ack) begin
						reqQ.cyc <= 1'b0;
						reqQ.stb <= 1'b0;
						state <= StDecode;
					end
				end
				StDecode: state <= ctrl.halt ? StHalted : StExecute;
				StExecute: begin
					if (ctrl.memRead || ctrl.memWrite) begin
						reqQ <= '{cyc: 1'b1, stb: 1'b1, we: ctrl.memWrite, adr: aluResult,
							datW: bQ};
						state <= StMemory;
					end else begin
						state <= StWriteBack;
					end
				end
				StMemory: begin
					if (busRsp.ack) begin
						reqQ.cyc <= 1'b0;
						reqQ.stb <= 1'b0;
						reqQ.we <= 1'b0;
						state <= StWriteBack;
					end
				end
				StWriteBack: begin
					// the next fetch goes out as this instruction retires.
					pc <= nextPcQ;
					reqQ <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: nextPcQ, datW: '0};
					state <= StFetch;
				end
				StHalted: state <= StHalted;
				default: state <= StHalted;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == StFetch && reqQ.cyc && busRsp.ack) irQ <= busRsp.datR;
		if (state == StDecode) begin
			aQ <= regDataA;
			bQ <= regDataB;
		end
		if (state == StExecute) begin
			aluOutQ <= aluResult;
			nextPcQ <= nextPc;
		end
		if (state == StMemory && busRsp.ack) mdrQ <= busRsp.datR;
	end
endmodule

`default_nettype wire

/* filelist.f */
cpuPkg.sv
busPkg.sv
controlUnit.sv
aluUnit.sv
registerFile.sv
datapath.sv
cpu.sv
cpu_checker.sv
cpuMonitor.sv
tbCpu.sv

/* registerFile.sv */
`default_nettype none

module registerFile (
	input logic clk,
	input logic rstN,
	input logic [cpuPkg::RegAddrWidth-1:0] readAddrA,
	input logic [cpuPkg::RegAddrWidth-1:0] readAddrB,
	input logic [cpuPkg::RegAddrWidth-1:0] writeAddr,
	input logic [cpuPkg::WordSize-1:0] writeData,
	input logic writeEnable,
	output logic [cpuPkg::WordSize-1:0] readDataA,
	output logic [cpuPkg::WordSize-1:0] readDataB
);
	logic [cpuPkg::WordSize-1:0] regs [cpuPkg::NumRegs];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < cpuPkg::NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

	// reads see the old value during a write cycle.
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];
endmodule

`default_nettype wire

/* tbCpu.sv */
`default_nettype none

module tbCpu;
	localparam int DoneTimeout = 30000;

	logic clk = 1'b0;
	logic rstN;
	busPkg::wbReqT busReq;
	busPkg::wbRspT busRsp;
	logic [cpuPkg::WordSize-1:0] outWord;
	logic outValid;
	logic halted;
	logic monDone;
	int testsRun;
	int testsFailed;

	logic [15:0] stim [0:511];
	logic [15:0] mem [0:255];
	int waitLeft = -1;

	always #10 clk = ~clk;

	cpu dut0 (
		.clk(clk), .rstN(rstN), .busReq(busReq), .busRsp(busRsp),
		.outWord(outWord), .outValid(outValid), .halted(halted)
	);

	cpuMonitor monitor0 (
		.clk(clk), .rstN(rstN), .busReq(busReq), .busRsp(busRsp),
		.outWord(outWord), .outValid(outValid), .halted(halted),
		.done(monDone), .testsRun(testsRun), .testsFailed(testsFailed)
	);

	// memory slave that acks after zero to three wait cycles.
	always begin
		@(posedge clk);
		#1;
		busRsp.ack = 1'b0;
		if (rstN && busReq.cyc && busReq.stb) begin
			if (waitLeft < 0) waitLeft = int'($urandom % 4);
			if (waitLeft == 0) begin
				busRsp.ack = 1'b1;
				busRsp.datR = mem[busReq.adr[7:0]];
				if (busReq.we) mem[busReq.adr[7:0]] = busReq.datW;
				waitLeft = -1;
			end else begin
				waitLeft--;
			end
		end
	end

	initial begin
		int cycles;
		void'($urandom(94449));
		rstN = 1'b0;
		busRsp = '0;
		for (int i = 0; i < 256; i++) begin
			stim[i] = 16'hA500 ^ 16'(i); // words that the image leaves out keep this pattern.
		end
		$readmemh("cpu_stim.txt", stim);
		for (int i = 0; i < 256; i++) begin
			mem[i] = stim[i];
		end
		repeat (3) @(posedge clk);
		#2;
		rstN = 1'b1;
		for (cycles = 0; cycles < DoneTimeout && !monDone; cycles++) begin
			@(posedge clk);
		end
		if (!monDone) begin
			$display("timeout waiting for the monitor to finish");
			$display("TEST FAILED");
		end else begin
			$display("%0d tests, %0d passed, %0d failed", testsRun,
				testsRun - testsFailed, testsFailed);
			if (testsFailed == 0) begin
				$display("TEST PASSED");
			end else begin
				$display("TEST FAILED");
			end
		end
		$finish;
	end
endmodule

`default_nettype wire
